// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
rtl/l2_pkg.sv
rtl/cache_ram.sv
rtl/req_decode.sv
rtl/way_select.sv
rtl/data_execute.sv
rtl/resp_result.sv
rtl/l2_cache_top.sv
testbench/tb_clock.sv
testbench/tb_top.sv

// File: rtl/cache_ram.sv
`timescale 1ns/1ns

// one way's array with a combinational read so a write is seen next cycle
module cache_ram
  import l2_pkg::*;
#(
  parameter type payload_t = logic [word_w-1:0],
  parameter int  depth     = num_sets
) (
  input  logic               clk,
  input  logic [index_w-1:0] rd_index,
  output payload_t           rd_data,
  input  logic               wr_en,
  input  logic [index_w-1:0] wr_index,
  input  payload_t           wr_data
);

  payload_t mem [depth];

  assign rd_data = mem[rd_index];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_index] <= wr_data;
    end
  end

endmodule

// File: rtl/data_execute.sv
`timescale 1ns/1ns

module data_execute
  import l2_pkg::*;
(
  input  logic              clk,
  input  stage_t            stage,
  input  way_sel_t          sel,
  output logic [word_w-1:0] line_data
);

  logic [word_w-1:0] rd_word [num_ways];
  logic [word_w-1:0] old_word;
  logic [word_w-1:0] merged;
  logic [ben_w-1:0]  eff_ben;

  for (genvar w = 0; w < num_ways; w++) begin : g_way
    cache_ram #(
      .payload_t(logic [word_w-1:0]),
      .depth    (num_sets)
    ) u_data_ram (
      .clk     (clk),
      .rd_index(stage.index),
      .rd_data (rd_word[w]),
      .wr_en   (sel.wr_en && sel.way == way_w'(w)),
      .wr_index(stage.index),
      .wr_data (merged)
    );
  end

  assign old_word = rd_word[sel.way];
  assign eff_ben  = (stage.op == op_read) ? '0 : stage.ben;  // reads never merge

  // read-modify-write byte by byte
  always_comb begin
    for (int b = 0; b < ben_w; b++) begin
      merged[8*b +: 8] = eff_ben[b] ? stage.wdata[8*b +: 8] : old_word[8*b +: 8];
    end
  end

  assign line_data = (sel.hit || stage.op == op_insert) ? merged : '0;

endmodule

// File: rtl/l2_cache_top.sv
`timescale 1ns/1ns

module l2_cache_top
  import l2_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  cache_req_t  req,
  output cache_resp_t resp
);

  stage_t            stage;
  way_sel_t          sel;
  logic [word_w-1:0] line_data;

  req_decode u_decode (
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .stage(stage)
  );

  // tags and data of the execute stage share the registered index
  way_select u_way_select (
    .clk  (clk),
    .rst  (rst),
    .stage(stage),
    .sel  (sel)
  );

  data_execute u_data_execute (
    .clk      (clk),
    .stage    (stage),
    .sel      (sel),
    .line_data(line_data)
  );

  resp_result u_result (
    .clk      (clk),
    .rst      (rst),
    .stage    (stage),
    .sel      (sel),
    .line_data(line_data),
    .resp     (resp)
  );

endmodule

// File: rtl/l2_pkg.sv
package l2_pkg;

  localparam int num_ways = 4;
  localparam int num_sets = 16;
  localparam int index_w  = 4;
  localparam int tag_w    = 8;
  localparam int way_w    = 2;
  localparam int word_w   = 32;
  localparam int ben_w    = 4;

  typedef enum logic [1:0] {
    op_read   = 2'd0,
    op_write  = 2'd1,
    op_insert = 2'd2
  } cache_op_t;

  typedef struct packed {
    logic                     valid;
    cache_op_t                op;
    logic [tag_w+index_w-1:0] addr;  // tag above index
    logic [word_w-1:0]        wdata;
    logic [ben_w-1:0]         ben;
  } cache_req_t;

  // decoded request with ben already forced for insert
  typedef struct packed {
    logic                valid;
    cache_op_t           op;
    logic [tag_w-1:0]    tag;
    logic [index_w-1:0]  index;
    logic [word_w-1:0]   wdata;
    logic [ben_w-1:0]    ben;
  } stage_t;

  typedef struct packed {
    logic             valid;
    logic [tag_w-1:0] tag;
  } tag_entry_t;

  typedef struct packed {
    logic             hit;
    logic [way_w-1:0] way;
    logic             wr_en;  // data store written this cycle
  } way_sel_t;

  typedef struct packed {
    logic              valid;
    logic              hit;
    logic [word_w-1:0] data;
  } cache_resp_t;

endpackage

// File: rtl/req_decode.sv
`timescale 1ns/1ns

module req_decode
  import l2_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  cache_req_t req,
  output stage_t     stage
);

  logic [tag_w-1:0]   req_tag;
  logic [index_w-1:0] req_index;
  logic [ben_w-1:0]   req_ben;

  assign req_tag   = req.addr[tag_w+index_w-1:index_w];
  assign req_index = req.addr[index_w-1:0];
  // a fill always replaces the whole word
  assign req_ben   = (req.op == op_insert) ? {ben_w{1'b1}} : req.ben;

  always_ff @(posedge clk) begin
    if (rst) begin
      stage.valid <= 1'b0;
    end else begin
      stage.valid <= req.valid;
    end
    stage.op    <= req.op;
    stage.tag   <= req_tag;
    stage.index <= req_index;
    stage.wdata <= req.wdata;
    stage.ben   <= req_ben;
  end

  // a store with no bytes enabled would still touch the LRU state
  assert property (@(posedge clk) disable iff (rst)
    req.valid && req.op == op_write |-> req.ben != '0)
    else $error("write request with empty byte enable");

endmodule

// File: rtl/resp_result.sv
`timescale 1ns/1ns

module resp_result
  import l2_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  stage_t            stage,
  input  way_sel_t          sel,
  input  logic [word_w-1:0] line_data,
  output cache_resp_t       resp
);

  always_ff @(posedge clk) begin
    if (rst) begin
      resp.valid <= 1'b0;
    end else begin
      resp.valid <= stage.valid;  // one pulse per decoded request
    end
    resp.hit  <= sel.hit;
    resp.data <= line_data;
  end

endmodule

// File: rtl/way_select.sv
`timescale 1ns/1ns

module way_select
  import l2_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  stage_t   stage,
  output way_sel_t sel
);

  tag_entry_t          tag_rd [num_ways];
  tag_entry_t          new_entry;
  logic [num_sets-1:0] valid_q [num_ways];
  logic [way_w-1:0]    age_q [num_sets][num_ways];
  logic [num_ways-1:0] hit_vec;
  logic [num_ways-1:0] age_seen;
  logic [way_w-1:0]    hit_way;
  logic [way_w-1:0]    victim;
  logic [way_w-1:0]    target_age;
  logic                is_insert;
  logic                lru_upd;

  assign is_insert = stage.valid && stage.op == op_insert;
  assign new_entry = '{valid: 1'b1, tag: stage.tag};

  for (genvar w = 0; w < num_ways; w++) begin : g_way
    cache_ram #(
      .payload_t(tag_entry_t),
      .depth    (num_sets)
    ) u_tag_ram (
      .clk     (clk),
      .rd_index(stage.index),
      .rd_data (tag_rd[w]),
      .wr_en   (is_insert && sel.way == way_w'(w)),
      .wr_index(stage.index),
      .wr_data (new_entry)
    );

    // stored entry is only trusted once its valid bit is set
    assign hit_vec[w] = valid_q[w][stage.index] && tag_rd[w].valid &&
                        tag_rd[w].tag == stage.tag;
  end

  always_comb begin
    hit_way = '0;
    victim  = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (hit_vec[w]) hit_way = way_w'(w);
      if (age_q[stage.index][w] == way_w'(num_ways - 1)) victim = way_w'(w);  // oldest
    end
  end

  always_comb begin
    sel.hit   = |hit_vec;
    sel.way   = sel.hit ? hit_way : victim;
    sel.wr_en = stage.valid &&
                ((stage.op == op_write && sel.hit) || stage.op == op_insert);
  end

  assign target_age = age_q[stage.index][sel.way];
  assign lru_upd    = stage.valid && (sel.hit || stage.op == op_insert);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < num_ways; w++) begin
        valid_q[w] <= '0;
      end
      for (int s = 0; s < num_sets; s++) begin
        for (int w = 0; w < num_ways; w++) begin
          age_q[s][w] <= way_w'(w);
        end
      end
    end else begin
      if (is_insert) valid_q[sel.way][stage.index] <= 1'b1;
      if (lru_upd) begin
        for (int w = 0; w < num_ways; w++) begin
          if (way_w'(w) == sel.way) begin
            age_q[stage.index][w] <= '0;  // most recent
          end else if (age_q[stage.index][w] < target_age) begin
            age_q[stage.index][w] <= age_q[stage.index][w] + 1'b1;
          end
        end
      end
    end
  end

  always_comb begin
    age_seen = '0;
    for (int w = 0; w < num_ways; w++) begin
      age_seen[age_q[stage.index][w]] = 1'b1;
    end
  end

  // inserts go to the victim only when the tag is absent
  assert property (@(posedge clk) disable iff (rst) stage.valid |-> $onehot0(hit_vec))
    else $error("more than one way hit in set %0d", stage.index);

  assert property (@(posedge clk) disable iff (rst) stage.valid |-> &age_seen)
    else $error("lru ages not a permutation in set %0d", stage.index);

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic rst
);

  localparam int half_period  = 4;  // 8 ns clock
  localparam int reset_cycles = 16;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;  // released away from the sampling edge
  end

endmodule

// File: testbench/tb_top.sv
`timescale 1ns/1ns

module tb_top
  import l2_pkg::*;
();

  localparam int n_fill   = 8;
  localparam int n_merge  = 6;
  localparam int n_miss   = 4;
  localparam int n_evict  = 10;
  localparam int n_burst  = 20;
  localparam int n_gapped = 10;
  localparam int n_random = 2000;
  localparam int total_steps = num_sets + 2 * n_fill + 3 * n_merge + 2 * n_miss + n_evict +
                               n_burst + n_gapped + n_random + num_ways;
  localparam int max_cycles  = total_steps + 50;

  logic        clk;
  logic        rst;
  cache_req_t  req;
  cache_resp_t resp;
  integer      seed;
  int          ncyc;
  int          run_cycles;

  // expected responses in request order
  cache_resp_t exp_q [$];
  int          due_q [$];
  string       name_q [$];

  logic              m_valid [num_sets][num_ways];
  logic [tag_w-1:0]  m_tag [num_sets][num_ways];
  logic [word_w-1:0] m_data [num_sets][num_ways];
  int                m_age [num_sets][num_ways];

  tb_clock u_clock (
    .clk(clk),
    .rst(rst)
  );

  l2_cache_top UUT (
    .clk (clk),
    .rst (rst),
    .req (req),
    .resp(resp)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_resp(input string name, input cache_resp_t exp, input cache_resp_t act);
    if (act.hit !== exp.hit || act.data !== exp.data) begin
      abort_run($sformatf("Error: %s expected hit=%0b data=%08h, actual hit=%0b data=%08h",
                          name, exp.hit, exp.data, act.hit, act.data));
    end
  endtask

  task automatic model_reset();
    for (int s = 0; s < num_sets; s++) begin
      for (int w = 0; w < num_ways; w++) begin
        m_valid[s][w] = 1'b0;
        m_tag[s][w]   = '0;
        m_data[s][w]  = '0;
        m_age[s][w]   = w;
      end
    end
  endtask

  task automatic model_apply(input cache_req_t r, output cache_resp_t e);
    logic [tag_w-1:0]   tag;
    logic [index_w-1:0] idx;
    logic               hit;
    int                 hit_way;
    int                 victim;
    int                 target;
    int                 t_age;
    tag     = r.addr[tag_w+index_w-1:index_w];
    idx     = r.addr[index_w-1:0];
    hit     = 1'b0;
    hit_way = 0;
    victim  = 0;
    for (int w = 0; w < num_ways; w++) begin
      if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
        hit     = 1'b1;
        hit_way = w;
      end
      if (m_age[idx][w] == num_ways - 1) victim = w;
    end
    target  = hit ? hit_way : victim;
    e.valid = 1'b1;
    e.hit   = hit;
    e.data  = '0;
    case (r.op)
      op_read: if (hit) e.data = m_data[idx][target];
      op_write: begin
        if (hit) begin
          for (int b = 0; b < ben_w; b++) begin
            if (r.ben[b]) m_data[idx][target][8*b +: 8] = r.wdata[8*b +: 8];
          end
          e.data = m_data[idx][target];
        end
      end
      op_insert: begin
        m_valid[idx][target] = 1'b1;
        m_tag[idx][target]   = tag;
        m_data[idx][target]  = r.wdata;
        e.data               = r.wdata;
      end
      default: ;
    endcase
    if (hit || r.op == op_insert) begin
      t_age = m_age[idx][target];
      for (int w = 0; w < num_ways; w++) begin
        if (w == target) m_age[idx][w] = 0;
        else if (m_age[idx][w] < t_age) m_age[idx][w] = m_age[idx][w] + 1;
      end
    end
  endtask

  task automatic check_output();
    cache_resp_t exp;
    string       name;
    if (resp.valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        abort_run("a response arrived with no request outstanding");
      end else if (due_q[0] != ncyc) begin
        abort_run($sformatf("response for %s arrived in the wrong cycle", name_q[0]));
      end else begin
        exp  = exp_q.pop_front();
        name = name_q.pop_front();
        void'(due_q.pop_front());
        check_resp(name, exp, resp);
      end
    end else if (exp_q.size() != 0 && due_q[0] <= ncyc) begin
      abort_run($sformatf("no response came for a request of %s", name_q[0]));
    end
  endtask

  // check the output on the falling edge and then drive the next request
  task automatic step(input cache_req_t r, input string name);
    cache_resp_t e;
    @(negedge clk);
    ncyc++;
    check_output();
    req = r;
    if (r.valid) begin
      model_apply(r, e);
      exp_q.push_back(e);
      due_q.push_back(ncyc + 2);
      name_q.push_back(name);
    end
  endtask

  function automatic cache_req_t make_req(input cache_op_t op, input logic [tag_w-1:0] tag,
                                          input logic [index_w-1:0] idx,
                                          input logic [word_w-1:0] wdata,
                                          input logic [ben_w-1:0] ben);
    cache_req_t r;
    r.valid = 1'b1;
    r.op    = op;
    r.addr  = {tag, idx};
    r.wdata = wdata;
    r.ben   = ben;
    return r;
  endfunction

  // 8 tags over sets 3 and 12
  task automatic random_req(output cache_req_t r);
    logic [31:0] rnd_op;
    logic [31:0] rnd_addr;
    rnd_op   = $random(seed);
    rnd_addr = $random(seed);
    r.valid  = 1'b1;
    if (rnd_op % 10 < 4) r.op = op_read;
    else if (rnd_op % 10 < 7) r.op = op_write;
    else r.op = op_insert;
    r.addr  = {5'b01000, rnd_addr[2:0], (rnd_addr[3] ? 4'd3 : 4'd12)};
    r.wdata = $random(seed);
    r.ben   = (rnd_addr[7:4] != 4'h0) ? rnd_addr[7:4] : 4'hf;
  endtask

  initial begin
    run_cycles = 0;
    @(negedge rst);
    while (run_cycles < max_cycles) begin
      @(posedge clk);
      run_cycles++;
    end
    abort_run($sformatf("timeout after %0d cycles, the run did not finish", run_cycles));
  end

  initial begin
    logic [31:0]      rnd;
    logic [ben_w-1:0] ben;
    cache_req_t       r;
    seed = 35;
    ncyc = 0;
    req  = '0;
    model_reset();
    @(negedge rst);

    for (int s = 0; s < num_sets; s++) begin
      rnd = $random(seed);
      step(make_req(op_read, rnd[7:0], index_w'(s), '0, 4'hf), "reset_read_miss");
    end

    for (int i = 0; i < n_fill; i++) begin  // read right behind the fill
      rnd = $random(seed);
      step(make_req(op_insert, tag_w'(8'h20 + i), 4'd5, rnd, 4'hf), "fill_then_read");
      step(make_req(op_read, tag_w'(8'h20 + i), 4'd5, '0, 4'hf), "fill_then_read");
    end

    for (int i = 0; i < n_merge; i++) begin
      rnd = $random(seed);
      step(make_req(op_insert, tag_w'(8'h90 + i), 4'd9, rnd, 4'hf), "write_merge");
      rnd = $random(seed);
      ben = (rnd[3:0] != 4'h0) ? rnd[3:0] : 4'h5;
      rnd = $random(seed);
      step(make_req(op_write, tag_w'(8'h90 + i), 4'd9, rnd, ben), "write_merge");
      step(make_req(op_read, tag_w'(8'h90 + i), 4'd9, '0, 4'hf), "write_merge");
    end
    for (int i = 0; i < n_miss; i++) begin
      rnd = $random(seed);
      step(make_req(op_write, tag_w'(8'he0 + i), 4'd9, rnd, 4'hf), "write_miss");
      step(make_req(op_read, tag_w'(8'he0 + i), 4'd9, '0, 4'hf), "write_miss");
    end
    for (int i = n_merge - num_ways; i < n_merge; i++) begin  // resident lines untouched
      step(make_req(op_read, tag_w'(8'h90 + i), 4'd9, '0, 4'hf), "write_miss");
    end

    // five tags into four ways so the first one goes
    for (int i = 0; i < 5; i++) begin
      rnd = $random(seed);
      step(make_req(op_insert, tag_w'(8'h10 + i), 4'd14, rnd, 4'hf), "lru_evict");
    end
    for (int i = 0; i < 5; i++) begin
      step(make_req(op_read, tag_w'(8'h10 + i), 4'd14, '0, 4'hf), "lru_evict");
    end

    for (int i = 0; i < n_burst; i++) begin
      random_req(r);
      step(r, "back_to_back");
    end
    for (int i = 0; i < n_gapped; i++) begin
      if (i % 2 == 0) random_req(r);
      else r = '0;
      step(r, "gapped");
    end

    for (int i = 0; i < n_random; i++) begin
      random_req(r);
      step(r, "random_mix");
    end

    for (int i = 0; i < 5; i++) begin
      step('0, "drain");
    end
    if (exp_q.size() == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      abort_run("responses still outstanding at the end of the run");
    end
  end

endmodule
